// File: build.f
common/fcpu_pkg.sv
common/mfu_pkg.sv
design/fifo.sv
mfu/operand_station.sv
mfu/address_unit.sv
mfu/store_buffer.sv
mfu/load_store_select.sv
mfu/memory_functional_unit.sv
sim/tb_memory_functional_unit.sv

// File: Bender.yml
package:
  name: memory_functional_unit

sources:
  - common/fcpu_pkg.sv
  - common/mfu_pkg.sv
  - design/fifo.sv
  - mfu/operand_station.sv
  - mfu/address_unit.sv
  - mfu/store_buffer.sv
  - mfu/load_store_select.sv
  - mfu/memory_functional_unit.sv
  - target: simulation
    files:
      - sim/tb_memory_functional_unit.sv

// File: sim/tb_memory_functional_unit.sv
`timescale 1ns/1ps

module tb_memory_functional_unit;

   import fcpu_pkg::*;
   import mfu_pkg::*;

   logic     clk;
   logic     nrst;
   issue_t   i_issue;
   logic     i_issue_valid;
   logic     o_issue_ready;
   cdb_t     i_cdb;
   logic     i_cdb_valid;
   commit_t  i_commit;
   logic     i_commit_valid;
   cdb_t     o_cdb;
   logic     o_cdb_valid;
   logic     i_cdb_ready;
   mem_req_t o_mem;
   logic     o_mem_valid;
   logic     i_mem_ready;

   logic [31:0]         rng;
   logic [RSV_ID_W-1:0] rob_next;
   mem_req_t            store_list[$];   // issued stores not yet committed
   mem_req_t            exp_load[$];
   mem_req_t            exp_store[$];
   cdb_t                exp_cdb[$];
   mem_req_t            obs_mem[$];
   cdb_t                obs_cdb[$];
   logic                mem_held;
   logic                cdb_held;
   mem_req_t            held_mem;
   cdb_t                held_cdb;

   memory_functional_unit dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [RSV_ID_W-1:0] next_rob();
      rob_next = rob_next + 1'b1;
      return rob_next;
   endfunction

   function automatic logic [31:0] ref_address(opcode_e op, logic [31:0] base, logic [31:0] off);
      if (op == I_LOADB || op == I_STOREB) begin
         return base - off;   // the B variants count down
      end
      return base + off;
   endfunction

   function automatic logic writes_memory(opcode_e op);
      return op inside {I_STORE, I_STOREB, I_STORER, I_OUTPUT};
   endfunction

   // youngest uncommitted store to this address
   function automatic logic [31:0] forward_value(logic [31:0] addr);
      logic [31:0] value;
      value = 'x;
      foreach (store_list[i]) begin
         if (store_list[i].addr == addr) begin
            value = store_list[i].data;
         end
      end
      return value;
   endfunction

   function automatic operand_t filled_op(logic [31:0] value);
      return '{tag: '0, value: value, filled: 1'b1};
   endfunction

   function automatic operand_t pending_op(logic [RSV_ID_W-1:0] tag);
      return '{tag: tag, value: '0, filled: 1'b0};
   endfunction

   function automatic issue_t make_issue(logic [RSV_ID_W-1:0] rob, opcode_e op, operand_t base,
                                         operand_t off, operand_t data);
      return '{rob_id: rob, opcode: op, base: base, offset: off, data: data};
   endfunction

   task automatic report_error(string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         report_error($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_mem_req(string name, mem_req_t got, mem_req_t exp);
      logic bad;
      bad = (got.rob_id !== exp.rob_id) || (got.opcode !== exp.opcode)
            || (got.addr !== exp.addr);
      if (writes_memory(exp.opcode) && got.data !== exp.data) begin
         bad = 1'b1;   // load data field is don't care
      end
      if (bad) begin
         report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_cdb(string name, cdb_t got, cdb_t exp);
      if (got !== exp) begin
         report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   // callers sit 1 ns after a rising edge
   task automatic issue_op(issue_t it);
      int  n;
      logic done;
      i_issue       = it;
      i_issue_valid = 1'b1;
      n             = 0;
      done          = 1'b0;
      while (!done) begin
         @(posedge clk);
         done = (o_issue_ready === 1'b1);
         n++;
         if (!done && n >= 200) begin
            report_error("timeout waiting for o_issue_ready");
         end
      end
      #1;
      i_issue_valid = 1'b0;
   endtask

   task automatic expect_load(logic [RSV_ID_W-1:0] rob, opcode_e op, logic [31:0] base,
                              logic [31:0] off);
      exp_load.push_back('{rob_id: rob, opcode: op, addr: ref_address(op, base, off), data: '0});
   endtask

   task automatic issue_store(logic [RSV_ID_W-1:0] rob, opcode_e op, logic [31:0] base,
                              logic [31:0] off, operand_t data, logic [31:0] final_data);
      store_list.push_back('{rob_id: rob, opcode: op, addr: ref_address(op, base, off),
                             data: final_data});
      issue_op(make_issue(rob, op, filled_op(base), filled_op(off), data));
   endtask

   task automatic broadcast(logic [RSV_ID_W-1:0] tag, logic [31:0] value);
      int delay;
      delay = next_rand() % 4;
      repeat (delay) begin
         @(posedge clk);
         #1;
      end
      i_cdb       = '{tag: tag, data: value};
      i_cdb_valid = 1'b1;
      @(posedge clk);
      #1;
      i_cdb_valid = 1'b0;
   endtask

   task automatic commit_store(logic [RSV_ID_W-1:0] rob, logic inval);
      int idx;
      idx = -1;
      foreach (store_list[i]) begin
         if (store_list[i].rob_id == rob) begin
            idx = i;
         end
      end
      if (idx < 0) begin
         report_error("commit for a store that was never issued");
      end
      if (!inval) begin
         exp_store.push_back(store_list[idx]);   // buffer drains in issue order
      end
      store_list.delete(idx);
      i_commit       = '{rob_id: rob, invalidate: inval};
      i_commit_valid = 1'b1;
      @(posedge clk);
      #1;
      i_commit_valid = 1'b0;
   endtask

   task automatic wait_drain(string what);
      int n;
      n = 0;
      while (exp_load.size() + exp_store.size() + exp_cdb.size()
             + obs_mem.size() + obs_cdb.size() != 0) begin
         @(posedge clk);
         #1;
         n++;
         if (n >= 1000) begin
            report_error($sformatf("timeout waiting for %s", what));
         end
      end
   endtask

   // random back-pressure on both outputs
   initial begin
      i_mem_ready = 1'b0;
      i_cdb_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         i_mem_ready = (next_rand() % 4) != 0;
         i_cdb_ready = (next_rand() % 4) != 0;
      end
   end

   // handshake monitor, also checks held outputs
   always @(posedge clk) begin
      if (!nrst) begin
         if (mem_held) begin
            check_bit("o_mem_valid", o_mem_valid, 1'b1);
            check_mem_req("o_mem held", o_mem, held_mem);
         end
         if (cdb_held) begin
            check_bit("o_cdb_valid", o_cdb_valid, 1'b1);
            check_cdb("o_cdb held", o_cdb, held_cdb);
         end
         if (o_mem_valid && i_mem_ready) begin
            obs_mem.push_back(o_mem);
         end
         if (o_cdb_valid && i_cdb_ready) begin
            obs_cdb.push_back(o_cdb);
         end
         mem_held = (o_mem_valid === 1'b1) && !i_mem_ready;
         cdb_held = (o_cdb_valid === 1'b1) && !i_cdb_ready;
         held_mem = o_mem;
         held_cdb = o_cdb;
      end
   end

   always @(negedge clk) begin
      mem_req_t got;
      while (obs_mem.size() > 0) begin
         got = obs_mem.pop_front();
         if (writes_memory(got.opcode)) begin
            if (exp_store.size() == 0) begin
               report_error("store request on o_mem that was not expected");
            end
            check_mem_req("o_mem", got, exp_store.pop_front());
         end else begin
            if (exp_load.size() == 0) begin
               report_error("load request on o_mem that was not expected");
            end
            check_mem_req("o_mem", got, exp_load.pop_front());
         end
      end
      while (obs_cdb.size() > 0) begin
         if (exp_cdb.size() == 0) begin
            report_error("result on o_cdb that was not expected");
         end
         check_cdb("o_cdb", obs_cdb.pop_front(), exp_cdb.pop_front());
      end
   end

   initial begin
      opcode_e             load_ops[4];
      logic [31:0]         base;
      logic [31:0]         off;
      logic [31:0]         addr;
      logic [31:0]         d1;
      logic [31:0]         d2;
      logic [RSV_ID_W-1:0] r1;
      logic [RSV_ID_W-1:0] r2;
      logic [RSV_ID_W-1:0] r3;
      opcode_e             op;
      rng            = 32'h60099d86;
      rob_next       = '0;
      mem_held       = 1'b0;
      cdb_held       = 1'b0;
      load_ops       = '{I_LOAD, I_LOADB, I_INPUT, I_LOADR};
      nrst           = 1'b1;
      i_issue        = '0;
      i_issue_valid  = 1'b0;
      i_cdb          = '0;
      i_cdb_valid    = 1'b0;
      i_commit       = '0;
      i_commit_valid = 1'b0;
      repeat (10) begin
         @(posedge clk);
      end
      check_bit("o_issue_ready", o_issue_ready, 1'b0);
      #1;
      nrst = 1'b0;
      @(posedge clk);
      check_bit("o_mem_valid", o_mem_valid, 1'b0);
      check_bit("o_cdb_valid", o_cdb_valid, 1'b0);
      #1;

      // loads with ready operands, empty store buffer
      for (int i = 0; i < 3; i++) begin
         base = next_rand();
         off  = next_rand() & 32'hffff;
         r1   = next_rob();
         expect_load(r1, load_ops[i], base, off);
         issue_op(make_issue(r1, load_ops[i], filled_op(base), filled_op(off), filled_op('0)));
      end
      wait_drain("the plain loads");

      // both operands arrive later by CDB
      base = next_rand();
      off  = next_rand() & 32'hffff;
      r1   = next_rob();
      expect_load(r1, I_LOADR, base, off);
      issue_op(make_issue(r1, I_LOADR, pending_op(4'hc), pending_op(4'hd), filled_op('0)));
      broadcast(4'hc, base);
      broadcast(4'hd, off);
      wait_drain("the load with CDB operands");

      // two stores to one address, load forwards from the younger
      addr = next_rand();
      off  = next_rand() & 32'hff;
      d1   = next_rand();
      d2   = next_rand();
      r1   = next_rob();
      r2   = next_rob();
      r3   = next_rob();
      issue_store(r1, I_STORE, addr - off, off, filled_op(d1), d1);
      issue_store(r2, I_STOREB, addr + off, off, pending_op(4'he), d2);
      exp_cdb.push_back('{tag: r3, data: forward_value(addr)});
      issue_op(make_issue(r3, I_LOADR, filled_op(addr), filled_op('0), filled_op('0)));
      broadcast(4'he, d2);   // store data after the load
      wait_drain("the forwarded load");
      commit_store(r1, 1'b1);
      commit_store(r2, 1'b0);
      wait_drain("the store after forwarding");

      // stores held until commit, middle one dropped
      r1 = next_rob();
      r2 = next_rob();
      r3 = next_rob();
      issue_store(r1, I_STORE, next_rand(), next_rand() & 32'hffff, filled_op(d1), d1);
      issue_store(r2, I_STOREB, next_rand(), next_rand() & 32'hffff, filled_op(d2), d2);
      issue_store(r3, I_OUTPUT, next_rand() & 32'hff, 32'h0, filled_op(~d1), ~d1);
      repeat (20) begin
         @(posedge clk);
         #1;
      end
      commit_store(r1, 1'b0);
      commit_store(r2, 1'b1);
      commit_store(r3, 1'b0);
      wait_drain("the committed stores");

      // stream of loads under random back-pressure
      for (int i = 0; i < 8; i++) begin
         op   = load_ops[next_rand() % 4];
         base = next_rand();
         off  = next_rand() & 32'hffff;
         r1   = next_rob();
         expect_load(r1, op, base, off);
         if (next_rand() % 2) begin
            issue_op(make_issue(r1, op, pending_op(4'hc), filled_op(off), filled_op('0)));
            broadcast(4'hc, base);
         end else begin
            issue_op(make_issue(r1, op, filled_op(base), filled_op(off), filled_op('0)));
         end
      end
      wait_drain("the load stream");

      if (store_list.size() != 0 || exp_load.size() + exp_store.size() + exp_cdb.size() != 0) begin
         $display("expected results left over at the end of the run");
         $display("CHECKS FAILED");
         $fatal(1, "run ended with missing results");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// File: mfu/memory_functional_unit.sv
`timescale 1ns/1ps

module memory_functional_unit (
   input  logic              clk,
   input  logic              nrst,
   input  mfu_pkg::issue_t   i_issue,
   input  logic              i_issue_valid,
   output logic              o_issue_ready,
   input  fcpu_pkg::cdb_t    i_cdb,
   input  logic              i_cdb_valid,
   input  mfu_pkg::commit_t  i_commit,
   input  logic              i_commit_valid,
   output fcpu_pkg::cdb_t    o_cdb,
   output logic              o_cdb_valid,
   input  logic              i_cdb_ready,
   output mfu_pkg::mem_req_t o_mem,
   output logic              o_mem_valid,
   input  logic              i_mem_ready
);

   import fcpu_pkg::*;
   import mfu_pkg::*;

   issue_t            disp;
   logic              disp_valid;
   logic              au_ready;
   logic              os_ready;
   addr_entry_t       q_head;
   logic              q_head_valid;
   logic              q_pop;
   logic              addr_write;
   logic              sb_full;
   logic              sb_push_valid;
   logic              hit;
   logic              hit_ready;
   logic [DATA_W-1:0] hit_data;
   logic              unresolved;
   mem_req_t          sb_head;
   logic              sb_head_ready;
   logic              sb_drop;
   logic              sb_pop;

   // stores enter the buffer in their issue cycle
   assign o_issue_ready = os_ready && !sb_full;
   assign sb_push_valid = i_issue_valid && o_issue_ready && is_store(i_issue.opcode);

   operand_station u_station (
      .clk           (clk),
      .nrst          (nrst),
      .i_issue       (i_issue),
      .i_issue_valid (i_issue_valid && !sb_full),
      .i_cdb         (i_cdb),
      .i_cdb_valid   (i_cdb_valid),
      .i_ready       (au_ready),
      .o_issue_ready (os_ready),
      .o_disp        (disp),
      .o_valid       (disp_valid)
   );

   address_unit u_addr (
      .clk          (clk),
      .nrst         (nrst),
      .i_disp       (disp),
      .i_valid      (disp_valid),
      .i_head_ready (q_pop),
      .o_ready      (au_ready),
      .o_head       (q_head),
      .o_head_valid (q_head_valid)
   );

   store_buffer u_sbuf (
      .clk            (clk),
      .nrst           (nrst),
      .i_push         (i_issue),
      .i_push_valid   (sb_push_valid),
      .i_cdb          (i_cdb),
      .i_cdb_valid    (i_cdb_valid),
      .i_addr         (q_head),
      .i_addr_write   (addr_write),
      .i_commit       (i_commit),
      .i_commit_valid (i_commit_valid),
      .i_pop          (sb_pop),
      .o_full         (sb_full),
      .o_hit          (hit),
      .o_hit_ready    (hit_ready),
      .o_hit_data     (hit_data),
      .o_unresolved   (unresolved),
      .o_head         (sb_head),
      .o_head_ready   (sb_head_ready),
      .o_head_drop    (sb_drop)
   );

   load_store_select u_select (
      .clk             (clk),
      .nrst            (nrst),
      .i_head          (q_head),
      .i_head_valid    (q_head_valid),
      .i_hit           (hit),
      .i_hit_ready     (hit_ready),
      .i_hit_data      (hit_data),
      .i_unresolved    (unresolved),
      .i_sb_head       (sb_head),
      .i_sb_head_ready (sb_head_ready),
      .i_cdb_ready     (i_cdb_ready),
      .i_mem_ready     (i_mem_ready),
      .o_head_pop      (q_pop),
      .o_addr_write    (addr_write),
      .o_sb_pop        (sb_pop),
      .o_cdb           (o_cdb),
      .o_cdb_valid     (o_cdb_valid),
      .o_mem           (o_mem),
      .o_mem_valid     (o_mem_valid)
   );

   // an invalidated store must never reach memory
   assert property (@(posedge clk) disable iff (nrst) !(sb_drop && sb_pop))
      else $error("invalidated store sent to memory");

endmodule

// File: mfu/load_store_select.sv
`timescale 1ns/1ps

module load_store_select (
   input  logic                        clk,
   input  logic                        nrst,
   input  mfu_pkg::addr_entry_t        i_head,
   input  logic                        i_head_valid,
   input  logic                        i_hit,
   input  logic                        i_hit_ready,
   input  logic [fcpu_pkg::DATA_W-1:0] i_hit_data,
   input  logic                        i_unresolved,
   input  mfu_pkg::mem_req_t           i_sb_head,
   input  logic                        i_sb_head_ready,
   input  logic                        i_cdb_ready,
   input  logic                        i_mem_ready,
   output logic                        o_head_pop,
   output logic                        o_addr_write,
   output logic                        o_sb_pop,
   output fcpu_pkg::cdb_t              o_cdb,
   output logic                        o_cdb_valid,
   output mfu_pkg::mem_req_t           o_mem,
   output logic                        o_mem_valid
);

   import mfu_pkg::*;

   logic head_load;
   logic head_store;
   logic fwd;
   logic to_mem;
   logic sel_sb;
   logic sb_held;   // buffer store offered, not yet taken

   assign head_load  = i_head_valid && is_load(i_head.opcode);
   assign head_store = i_head_valid && is_store(i_head.opcode);

   // a held store keeps the port, loads start only after it leaves
   assign fwd    = head_load && i_hit && i_hit_ready && !i_unresolved && !sb_held;
   assign to_mem = head_load && !i_hit && !i_unresolved && !sb_held;

   // load at the queue head wins the port, no drain under a forward
   assign sel_sb = i_sb_head_ready && (sb_held || (!to_mem && !fwd));

   assign o_addr_write = head_store;   // store address lands in its buffer row
   assign o_head_pop   = head_store || (fwd && i_cdb_ready) || (to_mem && i_mem_ready);
   assign o_sb_pop     = sel_sb && i_mem_ready;

   assign o_cdb_valid = fwd;
   assign o_cdb       = '{tag: i_head.rob_id, data: i_hit_data};
   assign o_mem_valid = to_mem || sel_sb;

   always_comb begin
      if (to_mem) begin
         o_mem = '{rob_id: i_head.rob_id, opcode: i_head.opcode, addr: i_head.addr,
                   data: '0};
      end else begin
         o_mem = i_sb_head;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         sb_held <= 1'b0;
      end else begin
         sb_held <= sel_sb && !i_mem_ready;
      end
   end

   assert property (@(posedge clk) disable iff (nrst)
      o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem))
      else $error("o_mem changed while waiting for i_mem_ready");

   assert property (@(posedge clk) disable iff (nrst)
      o_cdb_valid && !i_cdb_ready |=> o_cdb_valid && $stable(o_cdb))
      else $error("o_cdb changed while waiting for i_cdb_ready");

endmodule

// File: mfu/store_buffer.sv
`timescale 1ns/1ps

module store_buffer (
   input  logic                        clk,
   input  logic                        nrst,
   input  mfu_pkg::issue_t             i_push,
   input  logic                        i_push_valid,
   input  fcpu_pkg::cdb_t              i_cdb,
   input  logic                        i_cdb_valid,
   input  mfu_pkg::addr_entry_t        i_addr,
   input  logic                        i_addr_write,
   input  mfu_pkg::commit_t            i_commit,
   input  logic                        i_commit_valid,
   input  logic                        i_pop,
   output logic                        o_full,
   output logic                        o_hit,
   output logic                        o_hit_ready,
   output logic [fcpu_pkg::DATA_W-1:0] o_hit_data,
   output logic                        o_unresolved,
   output mfu_pkg::mem_req_t           o_head,
   output logic                        o_head_ready,
   output logic                        o_head_drop
);

   import mfu_pkg::*;

   store_entry_t        sb [SB_DEPTH];
   store_entry_t        head_e;
   logic [SB_PTR_W-1:0] head;
   logic [SB_PTR_W-1:0] tail;
   logic                pop;

   assign head_e       = sb[head];
   assign o_full       = sb[tail].valid;   // tail caught up with head
   assign o_head_drop  = head_e.valid && head_e.committed && head_e.invalidate;
   assign o_head_ready = head_e.valid && head_e.committed && !head_e.invalidate
                         && head_e.addr_ready && head_e.data.filled;
   assign o_head       = '{rob_id: head_e.rob_id, opcode: head_e.opcode,
                           addr: head_e.addr, data: head_e.data.value};
   assign pop          = i_pop || o_head_drop;

   // lookup for the load at the queue head, later match is younger
   always_comb begin
      store_entry_t e;
      logic         gap;
      o_hit        = 1'b0;
      o_hit_ready  = 1'b0;
      o_hit_data   = '0;
      o_unresolved = 1'b0;
      gap          = 1'b0;
      for (int i = 0; i < SB_DEPTH; i++) begin
         e = sb[head + SB_PTR_W'(i)];
         if (e.valid && !e.addr_ready) begin
            gap = 1'b1;
         end else if (e.valid && gap) begin
            o_unresolved = 1'b1;   // older address still missing
         end
         if (e.valid && e.addr_ready && !e.override && !e.invalidate
             && e.addr == i_addr.addr) begin
            o_hit       = 1'b1;
            o_hit_ready = e.data.filled;
            o_hit_data  = e.data.value;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         head <= '0;
         tail <= '0;
         for (int i = 0; i < SB_DEPTH; i++) begin
            sb[i].valid <= 1'b0;
         end
      end else begin
         for (int i = 0; i < SB_DEPTH; i++) begin
            sb[i].data <= capture(sb[i].data, i_cdb, i_cdb_valid);
            if (i_addr_write && sb[i].valid) begin
               if (sb[i].rob_id == i_addr.rob_id) begin
                  sb[i].addr       <= i_addr.addr;
                  sb[i].addr_ready <= 1'b1;
               end else if (sb[i].addr_ready && sb[i].addr == i_addr.addr) begin
                  sb[i].override <= 1'b1;
               end
            end
            if (i_commit_valid && sb[i].valid && sb[i].rob_id == i_commit.rob_id) begin
               sb[i].committed  <= 1'b1;
               sb[i].invalidate <= i_commit.invalidate;
            end
         end
         if (i_push_valid) begin
            sb[tail] <= '{valid: 1'b1, rob_id: i_push.rob_id, opcode: i_push.opcode,
                          data: capture(i_push.data, i_cdb, i_cdb_valid), addr: '0,
                          addr_ready: 1'b0, committed: 1'b0, invalidate: 1'b0,
                          override: 1'b0};
            tail <= tail + 1'b1;
         end
         if (pop) begin
            sb[head].valid <= 1'b0;
            head           <= head + 1'b1;
         end
      end
   end

   // issue side must hold back stores while full
   assert property (@(posedge clk) disable iff (nrst) i_push_valid |-> !o_full)
      else $error("store pushed into a full buffer");

   assert property (@(posedge clk) disable iff (nrst)
      i_pop |-> head_e.valid && head_e.committed)
      else $error("store left the buffer before commit");

endmodule

// File: mfu/address_unit.sv
`timescale 1ns/1ps

module address_unit (
   input  logic                 clk,
   input  logic                 nrst,
   input  mfu_pkg::issue_t      i_disp,
   input  logic                 i_valid,
   input  logic                 i_head_ready,
   output logic                 o_ready,
   output mfu_pkg::addr_entry_t o_head,
   output logic                 o_head_valid
);

   import mfu_pkg::*;

   addr_entry_t entry;

   always_comb begin
      entry.rob_id = i_disp.rob_id;
      entry.opcode = i_disp.opcode;
      if (is_minus(i_disp.opcode)) begin
         entry.addr = i_disp.base.value - i_disp.offset.value;
      end else begin
         entry.addr = i_disp.base.value + i_disp.offset.value;
      end
   end

   fifo #(
      .WIDTH   ($bits(addr_entry_t)),
      .DEPTH_W (AQ_DEPTH_W)
   ) address_queue (
      .clk     (clk),
      .nrst    (nrst),
      .i_data  (entry),
      .i_valid (i_valid),
      .o_ready (o_ready),
      .o_data  (o_head),
      .o_valid (o_head_valid),
      .i_ready (i_head_ready)
   );

endmodule

// File: mfu/operand_station.sv
`timescale 1ns/1ps

module operand_station (
   input  logic            clk,
   input  logic            nrst,
   input  mfu_pkg::issue_t i_issue,
   input  logic            i_issue_valid,
   input  fcpu_pkg::cdb_t  i_cdb,
   input  logic            i_cdb_valid,
   input  logic            i_ready,
   output logic            o_issue_ready,
   output mfu_pkg::issue_t o_disp,
   output logic            o_valid
);

   import mfu_pkg::*;

   issue_t              slot [OS_DEPTH];
   issue_t              incoming;
   logic [OS_PTR_W-1:0] head;
   logic [OS_PTR_W-1:0] tail;
   logic [OS_PTR_W:0]   count;
   logic                active;     // low through reset
   logic                push;
   logic                pop;

   assign o_issue_ready = active && (count != OS_DEPTH);
   assign push          = i_issue_valid && o_issue_ready;

   // oldest entry only, keeps the address queue in program order
   assign o_disp  = slot[head];
   assign o_valid = (count != '0) && slot[head].base.filled && slot[head].offset.filled;
   assign pop     = o_valid && i_ready;

   // a broadcast in the issue cycle is caught here
   always_comb begin
      incoming        = i_issue;
      incoming.base   = capture(i_issue.base, i_cdb, i_cdb_valid);
      incoming.offset = capture(i_issue.offset, i_cdb, i_cdb_valid);
      incoming.data   = capture(i_issue.data, i_cdb, i_cdb_valid);
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         active <= 1'b0;
         head   <= '0;
         tail   <= '0;
         count  <= '0;
      end else begin
         active <= 1'b1;
         for (int i = 0; i < OS_DEPTH; i++) begin
            slot[i].base   <= capture(slot[i].base, i_cdb, i_cdb_valid);
            slot[i].offset <= capture(slot[i].offset, i_cdb, i_cdb_valid);
            slot[i].data   <= capture(slot[i].data, i_cdb, i_cdb_valid);
         end
         if (push) begin
            slot[tail] <= incoming;
            tail       <= tail + 1'b1;
         end
         if (pop) begin
            head <= head + 1'b1;
         end
         count <= count + push - pop;
      end
   end

endmodule

// File: design/fifo.sv
`timescale 1ns/1ps

module fifo #(
   parameter int WIDTH   = 32,
   parameter int DEPTH_W = 2
) (
   input  logic             clk,
   input  logic             nrst,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_valid,
   output logic             o_ready,
   output logic [WIDTH-1:0] o_data,
   output logic             o_valid,
   input  logic             i_ready
);

   logic [WIDTH-1:0] mem [2**DEPTH_W];
   logic [DEPTH_W:0] wr_ptr;
   logic [DEPTH_W:0] rd_ptr;
   logic [DEPTH_W:0] used;

   assign used    = wr_ptr - rd_ptr;
   assign o_ready = !used[DEPTH_W];     // msb set only when full
   assign o_valid = (used != '0);
   assign o_data  = mem[rd_ptr[DEPTH_W-1:0]];

   always_ff @(posedge clk) begin
      if (i_valid && o_ready) begin
         mem[wr_ptr[DEPTH_W-1:0]] <= i_data;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (i_valid && o_ready) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (o_valid && i_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // while full nothing is written, so the offered entry has to wait unchanged
   assert property (@(posedge clk) disable iff (nrst)
      i_valid && !o_ready |=> i_valid && $stable(i_data))
      else $error("entry offered to a full FIFO was withdrawn");

endmodule

// File: common/mfu_pkg.sv
package mfu_pkg;

   import fcpu_pkg::*;

   localparam int SB_DEPTH   = 4;
   localparam int SB_PTR_W   = 2;
   localparam int OS_DEPTH   = 4;
   localparam int OS_PTR_W   = 2;
   localparam int AQ_DEPTH_W = 2;

   typedef struct packed {
      logic [RSV_ID_W-1:0] tag;
      logic [DATA_W-1:0]   value;
      logic                filled;
   } operand_t;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rob_id;
      opcode_e             opcode;
      operand_t            base;
      operand_t            offset;
      operand_t            data;     // store data, unused by loads
   } issue_t;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rob_id;
      opcode_e             opcode;
      logic [DATA_W-1:0]   addr;
   } addr_entry_t;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rob_id;
      logic                invalidate;
   } commit_t;

   typedef struct packed {
      logic [RSV_ID_W-1:0] rob_id;
      opcode_e             opcode;
      logic [DATA_W-1:0]   addr;
      logic [DATA_W-1:0]   data;
   } mem_req_t;

   typedef struct packed {
      logic                valid;
      logic [RSV_ID_W-1:0] rob_id;
      opcode_e             opcode;
      operand_t            data;
      logic [DATA_W-1:0]   addr;
      logic                addr_ready;
      logic                committed;
      logic                invalidate;
      logic                override;   // a younger store wrote the same address
   } store_entry_t;

   function automatic logic is_store(opcode_e op);
      return op inside {I_STORE, I_STOREB, I_STORER, I_OUTPUT};
   endfunction

   function automatic logic is_load(opcode_e op);
      return op inside {I_LOAD, I_LOADB, I_LOADR, I_INPUT};
   endfunction

   function automatic logic is_minus(opcode_e op);
      return op inside {I_LOADB, I_STOREB};
   endfunction

   // fill a waiting operand from a matching broadcast
   function automatic operand_t capture(operand_t op, cdb_t cdb, logic cdb_valid);
      operand_t res;
      res = op;
      if (cdb_valid && !op.filled && op.tag == cdb.tag) begin
         res.value  = cdb.data;
         res.filled = 1'b1;
      end
      return res;
   endfunction

endpackage

// File: common/fcpu_pkg.sv
package fcpu_pkg;

   localparam int DATA_W   = 32;
   localparam int RSV_ID_W = 4;
   localparam int INSTR_W  = 5;

   typedef enum logic [INSTR_W-1:0] {
      I_NOP    = 5'h00,
      I_ADD    = 5'h01,
      I_SUB    = 5'h02,
      I_MUL    = 5'h03,
      I_JUMP   = 5'h04,
      I_BRANCH = 5'h05,
      I_LOAD   = 5'h08,
      I_LOADB  = 5'h09,   // base minus offset
      I_LOADR  = 5'h0a,
      I_INPUT  = 5'h0b,   // io space read
      I_STORE  = 5'h0c,
      I_STOREB = 5'h0d,
      I_STORER = 5'h0e,
      I_OUTPUT = 5'h0f
   } opcode_e;

   // one result on the common data bus
   typedef struct packed {
      logic [RSV_ID_W-1:0] tag;
      logic [DATA_W-1:0]   data;
   } cdb_t;

endpackage
